/* compile.f */
+incdir+include
hw/speckle_pkg.sv
hw/pixel_sequencer.sv
hw/pixel_ram.sv
hw/key_shifter.sv
hw/speckle_sensor_controller.sv
tb/tb_speckle_sensor_controller.sv

/* hw/key_shifter.sv */
`timescale 1ns/1ps

module key_shifter
    import speckle_pkg::*;
#(
    parameter int NB_DATA = DEF_NB_DATA,
    parameter int CLK_DIV = DEF_CLK_DIV
) (
    input  logic               clk,
    input  logic               i_rst,

    input  logic               i_rd_valid,
    input  logic [NB_DATA-1:0] i_rd_data,
    input  logic               i_rd_last,
    input  logic [NB_DATA-1:0] i_umbral,

    output logic               o_idle,
    output logic               o_chip_col_data,
    output logic               o_chip_col_clk,
    output logic               o_chip_key_wren
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    shift_state_e     state;
    shift_state_e     state_next;

    logic [DIV_W-1:0] div_cnt;
    logic             last_q;      // Bit closes a column
    logic             phase_end;
    logic             key_bit;

    // Strictly greater so equal gives 0
    assign key_bit = (i_rd_data > i_umbral);

    assign phase_end = (div_cnt == DIV_W'(CLK_DIV - 1));

    always_comb begin
        state_next = state;
        case (state)
            SH_IDLE: begin
                if (i_rd_valid) begin
                    state_next = SH_CLK_HIGH;
                end
            end
            SH_CLK_HIGH: begin
                if (phase_end) begin
                    state_next = SH_CLK_LOW;
                end
            end
            SH_CLK_LOW: begin
                // Key write strobe after a column's last bit
                if (phase_end) begin
                    state_next = last_q ? SH_KEY : SH_IDLE;
                end
            end
            SH_KEY: begin
                if (phase_end) begin
                    state_next = SH_IDLE;
                end
            end
            default: begin
                state_next = SH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state           <= SH_IDLE;
            div_cnt         <= '0;
            last_q          <= 1'b0;
            o_chip_col_data <= 1'b0;
        end else begin
            state <= state_next;

            // Divider restarts on every phase change
            if ((state == SH_IDLE) || phase_end) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            if ((state == SH_IDLE) && i_rd_valid) begin
                o_chip_col_data <= key_bit;   // Held until the next sample
                last_q          <= i_rd_last;
            end
        end
    end

    assign o_idle          = (state == SH_IDLE);
    assign o_chip_col_clk  = (state == SH_CLK_HIGH);
    assign o_chip_key_wren = (state == SH_KEY);

endmodule

/* hw/pixel_ram.sv */
`timescale 1ns/1ps

module pixel_ram
    import speckle_pkg::*;
#(
    parameter int COLS    = DEF_COLS,
    parameter int ROWS    = DEF_ROWS,
    parameter int NB_DATA = DEF_NB_DATA,
    localparam int DEPTH  = COLS * ROWS,
    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic               clk,

    input  logic               i_wr_en,
    input  logic [NB_DATA-1:0] i_wr_data,
    input  logic               i_rd_en,
    input  logic [ADDR_W-1:0]  i_addr,
    input  logic               i_col_last,

    output logic               o_rd_valid,
    output logic [NB_DATA-1:0] o_rd_data,
    output logic               o_rd_last
);

    logic [NB_DATA-1:0] mem [DEPTH];   // One frame kept across operations

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_addr] <= i_wr_data;
        end
        if (i_rd_en) begin
            o_rd_data <= mem[i_addr];
        end
        o_rd_valid <= i_rd_en;               // Tags line up with read data
        o_rd_last  <= i_rd_en && i_col_last;
    end

endmodule

/* hw/pixel_sequencer.sv */
`timescale 1ns/1ps

module pixel_sequencer
    import speckle_pkg::*;
#(
    parameter int COLS    = DEF_COLS,
    parameter int ROWS    = DEF_ROWS,
    parameter int NB_DATA = DEF_NB_DATA,
    localparam int DEPTH  = COLS * ROWS,
    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic               clk,
    input  logic               i_rst,

    input  logic               i_start,
    input  mode_e              i_mode,

    input  logic               i_adc_done,
    input  logic [NB_DATA-1:0] i_adc_val,

    input  logic               i_shift_idle,

    output logic               o_adc_trigger,
    output logic               o_wr_en,
    output logic [NB_DATA-1:0] o_wr_data,
    output logic               o_rd_en,
    output logic [ADDR_W-1:0]  o_addr,
    output logic               o_col_last,

    output logic               o_busy,
    output logic               o_done
);

    localparam int COL_W = (COLS > 1) ? $clog2(COLS) : 1;
    localparam int ROW_W = (ROWS > 1) ? $clog2(ROWS) : 1;

    seq_state_e         state;
    seq_state_e         state_next;

    logic [COL_W-1:0]   col_cnt;
    logic [ROW_W-1:0]   row_cnt;
    logic [NB_DATA-1:0] adc_q;      // Sample held for the write cycle
    logic               rd_settle;  // First cycle after a read request

    logic               start_ok;
    logic               row_last;
    logic               last_pixel;
    logic               shift_ready;
    logic               step;

    // Start accepted in idle and in the done cycle
    assign start_ok = i_start && ((state == SEQ_IDLE) || (state == SEQ_DONE));

    assign row_last   = (row_cnt == ROW_W'(ROWS - 1));
    assign last_pixel = row_last && (col_cnt == COL_W'(COLS - 1));

    // Shifter has taken the bit and finished with it
    assign shift_ready = (state == SEQ_WAIT_SHIFT) && !rd_settle && i_shift_idle;

    // One pixel finished in either mode
    assign step = (state == SEQ_WRITE) || shift_ready;

    always_comb begin
        state_next = state;
        case (state)
            SEQ_IDLE, SEQ_DONE: begin
                state_next = SEQ_IDLE;
                if (i_start) begin
                    state_next = (i_mode == MODE_SCAN) ? SEQ_TRIG : SEQ_READ;
                end
            end
            SEQ_TRIG: begin
                state_next = SEQ_WAIT_ADC;
            end
            SEQ_WAIT_ADC: begin
                if (i_adc_done) begin
                    state_next = SEQ_WRITE;
                end
            end
            SEQ_WRITE: begin
                state_next = last_pixel ? SEQ_DONE : SEQ_TRIG;
            end
            SEQ_READ: begin
                if (i_shift_idle) begin   // Never overtake the shifter
                    state_next = SEQ_WAIT_SHIFT;
                end
            end
            SEQ_WAIT_SHIFT: begin
                if (shift_ready) begin
                    state_next = last_pixel ? SEQ_DONE : SEQ_READ;
                end
            end
            default: begin
                state_next = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state     <= SEQ_IDLE;
            col_cnt   <= '0;
            row_cnt   <= '0;
            rd_settle <= 1'b0;
        end else begin
            state     <= state_next;
            rd_settle <= o_rd_en;
            if (start_ok) begin
                col_cnt <= '0;
                row_cnt <= '0;
            end else if (step) begin
                // Column outer, row inner
                if (row_last) begin
                    row_cnt <= '0;
                    col_cnt <= (col_cnt == COL_W'(COLS - 1)) ? '0 : col_cnt + 1'b1;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end
        end
    end

    // ADC value captured on done
    always_ff @(posedge clk) begin
        if ((state == SEQ_WAIT_ADC) && i_adc_done) begin
            adc_q <= i_adc_val;
        end
    end

    assign o_adc_trigger = (state == SEQ_TRIG);
    assign o_wr_en       = (state == SEQ_WRITE);
    assign o_wr_data     = adc_q;
    assign o_rd_en       = (state == SEQ_READ) && i_shift_idle;

    // Linear address column x ROWS + row
    assign o_addr     = ADDR_W'(col_cnt) * ADDR_W'(ROWS) + ADDR_W'(row_cnt);
    assign o_col_last = row_last;

    assign o_busy = (state != SEQ_IDLE) && (state != SEQ_DONE);
    assign o_done = (state == SEQ_DONE);

endmodule

/* hw/speckle_pkg.sv */
package speckle_pkg;

    // Default array geometry and timing
    localparam int DEF_COLS    = 24;
    localparam int DEF_ROWS    = 24;
    localparam int DEF_NB_DATA = 12;
    localparam int DEF_CLK_DIV = 4;   // Core cycles per serial clock phase

    // Operation requested with the start strobe
    typedef enum logic {
        MODE_SCAN   = 1'b0,   // ADC samples into pixel memory
        MODE_CONFIG = 1'b1    // Key bits from memory to chip
    } mode_e;

    typedef enum logic [2:0] {
        SEQ_IDLE       = 3'd0,
        SEQ_TRIG       = 3'd1,
        SEQ_WAIT_ADC   = 3'd2,
        SEQ_WRITE      = 3'd3,
        SEQ_READ       = 3'd4,
        SEQ_WAIT_SHIFT = 3'd5,
        SEQ_DONE       = 3'd6
    } seq_state_e;

    typedef enum logic [1:0] {
        SH_IDLE     = 2'd0,
        SH_CLK_HIGH = 2'd1,
        SH_CLK_LOW  = 2'd2,
        SH_KEY      = 2'd3
    } shift_state_e;

endpackage

/* hw/speckle_sensor_controller.sv */
`timescale 1ns/1ps

module speckle_sensor_controller
    import speckle_pkg::*;
#(
    parameter int COLS    = DEF_COLS,
    parameter int ROWS    = DEF_ROWS,
    parameter int NB_DATA = DEF_NB_DATA,
    parameter int CLK_DIV = DEF_CLK_DIV
) (
    input  logic               clk,
    input  logic               i_rst,

    input  logic               i_start,
    input  mode_e              i_mode,

    input  logic [NB_DATA-1:0] i_adc_val,
    input  logic               i_adc_done,
    input  logic [NB_DATA-1:0] i_umbral,

    output logic               o_adc_trigger,

    output logic               o_chip_col_data,
    output logic               o_chip_col_clk,
    output logic               o_chip_key_wren,

    output logic               o_busy,
    output logic               o_done
);

    localparam int DEPTH  = COLS * ROWS;
    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Sequencer to memory
    logic               wr_en;
    logic [NB_DATA-1:0] wr_data;
    logic               rd_en;
    logic [ADDR_W-1:0]  addr;
    logic               col_last;

    // Memory to shifter
    logic               rd_valid;
    logic [NB_DATA-1:0] rd_data;
    logic               rd_last;

    logic               shift_idle;   // Back-pressure to the sequencer

    pixel_sequencer #(
        .COLS          ( COLS          ),
        .ROWS          ( ROWS          ),
        .NB_DATA       ( NB_DATA       )
    ) u_pixel_sequencer (
        .clk           ( clk           ),
        .i_rst         ( i_rst         ),
        .i_start       ( i_start       ),
        .i_mode        ( i_mode        ),
        .i_adc_done    ( i_adc_done    ),
        .i_adc_val     ( i_adc_val     ),
        .i_shift_idle  ( shift_idle    ),
        .o_adc_trigger ( o_adc_trigger ),
        .o_wr_en       ( wr_en         ),
        .o_wr_data     ( wr_data       ),
        .o_rd_en       ( rd_en         ),
        .o_addr        ( addr          ),
        .o_col_last    ( col_last      ),
        .o_busy        ( o_busy        ),
        .o_done        ( o_done        )
    );

    pixel_ram #(
        .COLS          ( COLS          ),
        .ROWS          ( ROWS          ),
        .NB_DATA       ( NB_DATA       )
    ) u_pixel_ram (
        .clk           ( clk           ),
        .i_wr_en       ( wr_en         ),
        .i_wr_data     ( wr_data       ),
        .i_rd_en       ( rd_en         ),
        .i_addr        ( addr          ),
        .i_col_last    ( col_last      ),
        .o_rd_valid    ( rd_valid      ),
        .o_rd_data     ( rd_data       ),
        .o_rd_last     ( rd_last       )
    );

    key_shifter #(
        .NB_DATA         ( NB_DATA         ),
        .CLK_DIV         ( CLK_DIV         )
    ) u_key_shifter (
        .clk             ( clk             ),
        .i_rst           ( i_rst           ),
        .i_rd_valid      ( rd_valid        ),
        .i_rd_data       ( rd_data         ),
        .i_rd_last       ( rd_last         ),
        .i_umbral        ( i_umbral        ),
        .o_idle          ( shift_idle      ),
        .o_chip_col_data ( o_chip_col_data ),
        .o_chip_col_clk  ( o_chip_col_clk  ),
        .o_chip_key_wren ( o_chip_key_wren )
    );

endmodule

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module tb_speckle_sensor_controller \
    -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "^Test passed$" &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* include/tb_helpers.svh */
`ifndef TB_HELPERS_SVH
`define TB_HELPERS_SVH

// Tallies for the closing line
int fail_count    = 0;
int timeout_count = 0;

// Frame as delivered by the ADC in address order
logic [NB_DATA-1:0] model_mem [PIXELS];
int                 model_fill = 0;   // Next address to record

logic [31:0] rng_state = SEED;

// 32-bit xorshift with shifts 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

function automatic void report_mismatch(input string name, input int expected,
                                        input int actual);
    fail_count++;
    $display("[FAIL] %0t %s expected %0d got %0d", $time, name, expected, actual);
endfunction

// Leaves the caller 1 ns past an edge
task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
endtask

// Polls o_done just after each edge
task automatic wait_for_done(input int max_cycles, input string what);
    int i;
    for (i = 0; i < max_cycles; i++) begin
        @(posedge clk);
        #1;
        if (o_done) begin
            return;
        end
    end
    timeout_count++;
    $display("Timeout: %s did not finish within %0d cycles", what, max_cycles);
endtask

`endif

/* tb/tb_speckle_sensor_controller.sv */
`timescale 1ns/1ps

module tb_speckle_sensor_controller
    import speckle_pkg::*;
();

    localparam int          COLS    = 4;
    localparam int          ROWS    = 3;
    localparam int          NB_DATA = 12;
    localparam int          CLK_DIV = 3;
    localparam int          PIXELS  = COLS * ROWS;
    localparam logic [31:0] SEED    = 32'h6b659cf4;
    localparam int          EQ_IDX  = 5;   // Sample forced onto the threshold

    localparam logic [NB_DATA-1:0] UMBRAL = {1'b1, {(NB_DATA - 1){1'b0}}};   // Mid-scale

    logic               clk;
    logic               i_rst;
    logic               i_start;
    mode_e              i_mode;
    logic [NB_DATA-1:0] i_adc_val;
    logic               i_adc_done;
    logic [NB_DATA-1:0] i_umbral;
    logic               o_adc_trigger;
    logic               o_chip_col_data;
    logic               o_chip_col_clk;
    logic               o_chip_key_wren;
    logic               o_busy;
    logic               o_done;

    `include "tb_helpers.svh"

    // Monitor state updated once per clock
    mode_e      op_mode     = MODE_SCAN;
    int         trig_count  = 0;
    int         bit_idx     = 0;   // Rising serial clocks so far
    int         wren_count  = 0;
    int         hi_len      = 0;
    int         lo_len      = CLK_DIV;
    int         wren_len    = 0;
    logic       col_clk_q   = 1'b0;
    logic       wren_q      = 1'b0;
    logic       adc_pending = 1'b0;
    logic       done_seen   = 1'b0;
    logic       start_taken;
    logic       exp_bit;
    logic       at_threshold;
    logic [5:0] quiet_outs;

    assign start_taken  = i_start && !o_busy;
    assign exp_bit      = (model_mem[bit_idx % PIXELS] > i_umbral);
    assign at_threshold = (model_mem[bit_idx % PIXELS] == i_umbral);
    assign quiet_outs   = {o_adc_trigger, o_chip_col_clk, o_chip_key_wren,
                           o_chip_col_data, o_busy, o_done};

    speckle_sensor_controller #(
        .COLS            ( COLS            ),
        .ROWS            ( ROWS            ),
        .NB_DATA         ( NB_DATA         ),
        .CLK_DIV         ( CLK_DIV         )
    ) uut (
        .clk             ( clk             ),
        .i_rst           ( i_rst           ),
        .i_start         ( i_start         ),
        .i_mode          ( i_mode          ),
        .i_adc_val       ( i_adc_val       ),
        .i_adc_done      ( i_adc_done      ),
        .i_umbral        ( i_umbral        ),
        .o_adc_trigger   ( o_adc_trigger   ),
        .o_chip_col_data ( o_chip_col_data ),
        .o_chip_col_clk  ( o_chip_col_clk  ),
        .o_chip_key_wren ( o_chip_key_wren ),
        .o_busy          ( o_busy          ),
        .o_done          ( o_done          )
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        col_clk_q <= o_chip_col_clk;
        wren_q    <= o_chip_key_wren;
        hi_len    <= o_chip_col_clk ? hi_len + 1 : 0;
        wren_len  <= o_chip_key_wren ? wren_len + 1 : 0;
        if (o_chip_col_clk) begin
            lo_len <= 0;
        end else if (lo_len < CLK_DIV) begin
            lo_len <= lo_len + 1;   // Saturates so the first rise after idle passes
        end
        if (o_adc_trigger) begin
            adc_pending <= 1'b1;
        end else if (i_adc_done) begin
            adc_pending <= 1'b0;
        end
        if (i_rst || start_taken) begin
            op_mode    <= i_rst ? MODE_SCAN : i_mode;
            trig_count <= 0;
            bit_idx    <= 0;
            wren_count <= 0;
            done_seen  <= 1'b0;
        end else begin
            if (o_adc_trigger) begin
                trig_count <= trig_count + 1;
            end
            if (o_chip_col_clk && !col_clk_q) begin
                bit_idx <= bit_idx + 1;
            end
            if (o_chip_key_wren && !wren_q) begin
                wren_count <= wren_count + 1;
            end
            if (o_done) begin
                done_seen <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) $past(i_rst) |-> quiet_outs == 6'd0)
        else report_mismatch("outputs after reset", 0, int'($sampled(quiet_outs)));

    // Scan
    assert property (@(posedge clk) disable iff (i_rst) $past(o_adc_trigger) |-> !o_adc_trigger)
        else report_mismatch("o_adc_trigger", 0, 1);
    assert property (@(posedge clk) disable iff (i_rst) o_adc_trigger |-> !adc_pending)
        else report_mismatch("i_adc_done before o_adc_trigger", 1, 0);
    assert property (@(posedge clk) disable iff (i_rst)
        (o_done && op_mode == MODE_SCAN) |-> trig_count == PIXELS)
        else report_mismatch("o_adc_trigger count", PIXELS, $sampled(trig_count));
    assert property (@(posedge clk) disable iff (i_rst)
        op_mode == MODE_CONFIG |-> !o_adc_trigger)
        else report_mismatch("o_adc_trigger in configure", 0, 1);
    assert property (@(posedge clk) disable iff (i_rst) o_done |-> $past(o_busy) && !o_busy)
        else report_mismatch("o_busy falling with o_done", 1, 0);
    assert property (@(posedge clk) disable iff (i_rst) o_done |-> !done_seen)
        else report_mismatch("o_done pulses", 1, 2);

    // Configure bits in address order
    assert property (@(posedge clk) disable iff (i_rst)
        $rose(o_chip_col_clk) |-> o_chip_col_data == exp_bit)
        else report_mismatch("o_chip_col_data", int'($sampled(exp_bit)),
                             int'($sampled(o_chip_col_data)));
    assert property (@(posedge clk) disable iff (i_rst)
        ($rose(o_chip_col_clk) && at_threshold) |-> !o_chip_col_data)
        else report_mismatch("o_chip_col_data at threshold", 0, 1);
    assert property (@(posedge clk) disable iff (i_rst)
        (o_done && op_mode == MODE_CONFIG) |-> bit_idx == PIXELS)
        else report_mismatch("o_chip_col_clk count", PIXELS, $sampled(bit_idx));

    // Serial clock shape
    assert property (@(posedge clk) disable iff (i_rst)
        $fell(o_chip_col_clk) |-> hi_len == CLK_DIV)
        else report_mismatch("o_chip_col_clk high cycles", CLK_DIV, $sampled(hi_len));
    assert property (@(posedge clk) disable iff (i_rst) o_chip_col_clk |-> hi_len < CLK_DIV)
        else report_mismatch("o_chip_col_clk high cycles", CLK_DIV, $sampled(hi_len) + 1);
    assert property (@(posedge clk) disable iff (i_rst)
        $rose(o_chip_col_clk) |-> lo_len >= CLK_DIV)
        else report_mismatch("o_chip_col_clk low cycles", CLK_DIV, $sampled(lo_len));
    assert property (@(posedge clk) disable iff (i_rst)
        $past(o_chip_col_clk) |-> $stable(o_chip_col_data))
        else report_mismatch("o_chip_col_data while clock high",
                             int'(!$sampled(o_chip_col_data)),
                             int'($sampled(o_chip_col_data)));

    // Key write strobe
    assert property (@(posedge clk) disable iff (i_rst)
        $fell(o_chip_key_wren) |-> wren_len == CLK_DIV)
        else report_mismatch("o_chip_key_wren cycles", CLK_DIV, $sampled(wren_len));
    assert property (@(posedge clk) disable iff (i_rst) o_chip_key_wren |-> wren_len < CLK_DIV)
        else report_mismatch("o_chip_key_wren cycles", CLK_DIV, $sampled(wren_len) + 1);
    assert property (@(posedge clk) disable iff (i_rst)
        $rose(o_chip_key_wren) |-> bit_idx == (wren_count + 1) * ROWS)
        else report_mismatch("bits before o_chip_key_wren", ($sampled(wren_count) + 1) * ROWS,
                             $sampled(bit_idx));
    assert property (@(posedge clk) disable iff (i_rst) o_chip_key_wren |-> !o_chip_col_clk)
        else report_mismatch("o_chip_col_clk during o_chip_key_wren", 0, 1);
    assert property (@(posedge clk) disable iff (i_rst)
        (o_done && op_mode == MODE_CONFIG) |-> wren_count == COLS)
        else report_mismatch("o_chip_key_wren count", COLS, $sampled(wren_count));

    // ADC model with random latency
    initial begin : adc_responder
        int                 delay;
        logic [31:0]        rnd;
        logic [NB_DATA-1:0] sample;
        i_adc_done = 1'b0;
        i_adc_val  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (o_adc_trigger) begin
                rnd    = next_random();
                delay  = 1 + int'(rnd % 32'd6);
                rnd    = next_random();
                sample = (model_fill == EQ_IDX) ? UMBRAL : rnd[NB_DATA-1:0];
                repeat (delay) @(posedge clk);
                #1;
                i_adc_val  = sample;
                i_adc_done = 1'b1;
                model_mem[model_fill % PIXELS] = sample;
                model_fill++;
                @(posedge clk);
                #1;
                i_adc_done = 1'b0;
            end
        end
    end

    task automatic pulse_start(input mode_e mode);
        i_mode  = mode;
        i_start = 1'b1;
        @(posedge clk);
        #1;
        i_start = 1'b0;
    endtask

    initial begin : stimulus
        i_rst    = 1'b1;
        i_start  = 1'b0;
        i_mode   = MODE_SCAN;
        i_umbral = UMBRAL;
        repeat (3) @(posedge clk);
        #1;
        i_rst = 1'b0;
        wait_cycles(2);

        pulse_start(MODE_SCAN);
        wait_cycles(10);
        pulse_start(MODE_CONFIG);   // Ignored while the scan is busy
        wait_for_done(40 * PIXELS, "scan");
        wait_cycles(3);

        pulse_start(MODE_CONFIG);
        wait_cycles(20);
        pulse_start(MODE_SCAN);
        wait_for_done(40 * PIXELS, "configure");
        wait_cycles(3);

        $display("Errors: %0d check failures, %0d timeouts", fail_count, timeout_count);
        if (fail_count == 0 && timeout_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
